/* include/exec_macros.svh */
// Widths are fixed at compile time; MDU_STEPS must equal XLEN and fit in STEP_W bits
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// ==========================================================
// Datapath widths
// ==========================================================

// Data word width for operands, results and memory-unit traffic
`define XLEN 32

// Multiply/divide unit handles one bit per iteration
`define MDU_STEPS 32

// Step counter must hold MDU_STEPS itself
`define STEP_W 6

// ==========================================================
// Field widths
// ==========================================================

// Multiply/divide operation code
`define MDU_OP_W 2

`endif

/* verilog/exec_data_pkg.sv */
// Data types only; all widths follow the macros in exec_macros.svh
`default_nettype none

`include "exec_macros.svh"

package exec_data_pkg;

    // ==========================================================
    // Data words and counts
    // ==========================================================

    // Operands, results, memory-unit address and data
    typedef logic [`XLEN-1:0] word_t;

    // Iterations left in the multiply/divide unit
    typedef logic [`STEP_W-1:0] step_count_t;

    // ==========================================================
    // Multiply/divide operations
    // ==========================================================

    // All divides are unsigned
    typedef enum logic [`MDU_OP_W-1:0] {
        MDU_MUL,    // Low word of the product
        MDU_DIVU,   // Quotient
        MDU_MODU    // Remainder
    } mdu_op_t;

endpackage

`default_nettype wire

/* verilog/exec_ctrl_pkg.sv */
// Control encodings for the stage; only one long operation is held at a time
`default_nettype none

package exec_ctrl_pkg;

    // Operation presented by upstream
    typedef enum logic [1:0] {
        OP_NONE,
        OP_MDU,
        OP_IO,
        OP_CLEAR_CACHE
    } op_kind_t;

    // Request sequencer, shared by all three units
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_STARTED,
        SEQ_WAIT_DONE
    } seq_state_t;

endpackage

`default_nettype wire

/* verilog/mdu_iteration_counter.sv */
// A new start is only legal once done has been seen; step runs for MDU_STEPS cycles
`default_nettype none

`include "exec_macros.svh"

module mdu_iteration_counter
    import exec_data_pkg::*;
(
    input  wire     clk,
    input  wire     reset,
    input  wire     start,
    output logic    step,
    output logic    done
);

    step_count_t count;

    // Datapath works whenever iterations remain
    assign step = (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            done  <= 1'b0;
        end else begin
            // Pulse once, in the cycle after the last step
            done <= step && (count == step_count_t'(1));
            if (start) begin
                count <= step_count_t'(`MDU_STEPS);
            end else if (step) begin
                count <= count - step_count_t'(1);
            end
        end
    end

    // The sequencer waits for done before it can issue again
    assert property (@(posedge clk) disable iff (reset)
        start |-> !step);

endmodule

`default_nettype wire

/* verilog/mdu_datapath.sv */
// Unsigned only; y is valid in the cycle done is pulsed and holds until the next start
`default_nettype none

`include "exec_macros.svh"

module mdu_datapath
    import exec_data_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             start,
    input  wire mdu_op_t    op,
    input  wire word_t      a,
    input  wire word_t      b,
    input  wire             step,
    output word_t           y
);

    // ==========================================================
    // Registers
    // ==========================================================

    // In a multiply shift_reg is the multiplicand moving left and opnd_b the multiplier
    // In a divide shift_reg takes the dividend in and the quotient out, with opnd_b as divisor
    mdu_op_t op_reg;
    word_t   shift_reg;
    word_t   opnd_b;
    word_t   acc;

    logic [`XLEN:0] partial;
    logic [`XLEN:0] diff;
    logic           fits;
    word_t          addend;

    // ==========================================================
    // Step logic
    // ==========================================================

    always_comb begin
        // Restoring divide trial subtraction
        partial = {acc, shift_reg[`XLEN-1]};
        diff    = partial - {1'b0, opnd_b};
        fits    = (partial >= {1'b0, opnd_b});
        // Shift-add multiply partial product
        addend  = opnd_b[0] ? shift_reg : '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_reg <= MDU_MUL;
            acc    <= '0;
        end else if (start) begin
            op_reg <= op;
            acc    <= '0;
        end else if (step) begin
            if (op_reg == MDU_MUL) begin
                acc <= acc + addend;
            end else if (fits) begin
                acc <= diff[`XLEN-1:0];
            end else begin
                acc <= partial[`XLEN-1:0];
            end
        end
    end

    // Operands load on start and shift once per step
    always_ff @(posedge clk) begin
        if (start) begin
            shift_reg <= a;
            opnd_b    <= b;
        end else if (step) begin
            if (op_reg == MDU_MUL) begin
                shift_reg <= shift_reg << 1;
                opnd_b    <= opnd_b >> 1;
            end else begin
                shift_reg <= {shift_reg[`XLEN-2:0], fits};
            end
        end
    end

    // A zero divisor makes every trial fit, so the quotient fills with ones
    // and the dividend bits pass unchanged into the remainder
    always_comb begin
        case (op_reg)
            MDU_DIVU: y = shift_reg;
            MDU_MODU: y = acc;
            default:  y = acc;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/long_op_sequencer.sv */
// Upstream must hold op_kind and operands while stall is high; no downstream back-pressure
`default_nettype none

module long_op_sequencer
    import exec_data_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire op_kind_t   op_kind,
    input  wire mdu_op_t    mdu_op,
    input  wire word_t      operand_a,
    input  wire word_t      operand_b,
    input  wire             io_write,

    output logic            stall,
    output word_t           result,
    output logic            result_valid,

    output logic            mu_start,
    output word_t           mu_addr,
    output word_t           mu_data,
    output logic            mu_we,
    input  wire word_t      mu_q,
    input  wire             mu_done,

    output logic            l1_clear_cache,
    input  wire             l1_clear_cache_done,

    output logic            mdu_start,
    output mdu_op_t         mdu_req_op,
    output word_t           mdu_req_a,
    output word_t           mdu_req_b,
    input  wire             mdu_done,
    input  wire word_t      mdu_y
);

    seq_state_t state;
    logic       finished;
    logic       unit_done;
    word_t      unit_result;

    // Done and result of the unit that serves the held operation
    always_comb begin
        unit_done   = 1'b0;
        unit_result = '0;
        case (op_kind)
            OP_MDU: begin
                unit_done   = mdu_done;
                unit_result = mdu_y;
            end
            OP_IO: begin
                unit_done   = mu_done;
                unit_result = mu_q;
            end
            OP_CLEAR_CACHE: unit_done = l1_clear_cache_done;  // result stays zero
            default: unit_done = 1'b0;
        endcase
    end

    assign stall        = (op_kind != OP_NONE) && !finished;
    assign result_valid = finished;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= SEQ_IDLE;
            finished       <= 1'b0;
            result         <= '0;
            mu_start       <= 1'b0;
            mu_addr        <= '0;
            mu_data        <= '0;
            mu_we          <= 1'b0;
            l1_clear_cache <= 1'b0;
            mdu_start      <= 1'b0;
            mdu_req_op     <= MDU_MUL;
            mdu_req_a      <= '0;
            mdu_req_b      <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    finished <= 1'b0;
                    result   <= '0;
                    // A finished flag blocks a second request for the same operation
                    if (op_kind != OP_NONE && !finished) begin
                        case (op_kind)
                            OP_MDU: begin
                                mdu_start  <= 1'b1;
                                mdu_req_op <= mdu_op;
                                mdu_req_a  <= operand_a;
                                mdu_req_b  <= operand_b;
                            end
                            OP_IO: begin
                                mu_start <= 1'b1;
                                mu_addr  <= operand_a;
                                mu_data  <= operand_b;
                                mu_we    <= io_write;
                            end
                            default: l1_clear_cache <= 1'b1;
                        endcase
                        state <= SEQ_STARTED;
                    end
                end

                SEQ_STARTED: begin
                    // Start pulses and request payload last one cycle
                    mu_start       <= 1'b0;
                    mu_addr        <= '0;
                    mu_data        <= '0;
                    mu_we          <= 1'b0;
                    l1_clear_cache <= 1'b0;
                    mdu_start      <= 1'b0;
                    mdu_req_op     <= MDU_MUL;
                    mdu_req_a      <= '0;
                    mdu_req_b      <= '0;
                    state          <= SEQ_WAIT_DONE;
                end

                SEQ_WAIT_DONE: begin
                    if (unit_done) begin
                        result   <= unit_result;
                        finished <= 1'b1;
                        state    <= SEQ_IDLE;
                    end
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // ==========================================================
    // Assertions
    // ==========================================================

    // Only one external request is ever in flight
    assert property (@(posedge clk) disable iff (reset)
        !(mu_start && l1_clear_cache));

    assert property (@(posedge clk) disable iff (reset)
        (op_kind == OP_NONE) |-> !stall);

    // Upstream moves on after the result, so it never repeats
    assert property (@(posedge clk) disable iff (reset)
        result_valid |=> !result_valid);

endmodule

`default_nettype wire

/* verilog/multicycle_exec_stage.sv */
// One long operation at a time; the I/O address is operand A without decoding
`default_nettype none

module multicycle_exec_stage
    import exec_data_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire op_kind_t   op_kind,
    input  wire mdu_op_t    mdu_op,
    input  wire word_t      operand_a,
    input  wire word_t      operand_b,
    input  wire             io_write,

    output logic            stall,
    output word_t           result,
    output logic            result_valid,

    output logic            mu_start,
    output word_t           mu_addr,
    output word_t           mu_data,
    output logic            mu_we,
    input  wire word_t      mu_q,
    input  wire             mu_done,

    output logic            l1_clear_cache,
    input  wire             l1_clear_cache_done
);

    // Internal multiply/divide handshake
    logic    mdu_start;
    logic    mdu_step;
    logic    mdu_done;
    mdu_op_t mdu_req_op;
    word_t   mdu_req_a;
    word_t   mdu_req_b;
    word_t   mdu_y;

    long_op_sequencer u_sequencer (
        .clk                 (clk),
        .reset               (reset),
        .op_kind             (op_kind),
        .mdu_op              (mdu_op),
        .operand_a           (operand_a),
        .operand_b           (operand_b),
        .io_write            (io_write),
        .stall               (stall),
        .result              (result),
        .result_valid        (result_valid),
        .mu_start            (mu_start),
        .mu_addr             (mu_addr),
        .mu_data             (mu_data),
        .mu_we               (mu_we),
        .mu_q                (mu_q),
        .mu_done             (mu_done),
        .l1_clear_cache      (l1_clear_cache),
        .l1_clear_cache_done (l1_clear_cache_done),
        .mdu_start           (mdu_start),
        .mdu_req_op          (mdu_req_op),
        .mdu_req_a           (mdu_req_a),
        .mdu_req_b           (mdu_req_b),
        .mdu_done            (mdu_done),
        .mdu_y               (mdu_y)
    );

    mdu_iteration_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .start (mdu_start),
        .step  (mdu_step),
        .done  (mdu_done)
    );

    mdu_datapath u_datapath (
        .clk   (clk),
        .reset (reset),
        .start (mdu_start),
        .op    (mdu_req_op),
        .a     (mdu_req_a),
        .b     (mdu_req_b),
        .step  (mdu_step),
        .y     (mdu_y)
    );

endmodule

`default_nettype wire

/* verification/tb_multicycle_exec_stage.sv */
// Responder models answer within 8 cycles; the memory model decodes only mu_addr[3:0]
`default_nettype none

module tb_multicycle_exec_stage
    import exec_data_pkg::*;
    import exec_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESULT_TIMEOUT = 200;

    logic       clk;
    logic       reset;
    op_kind_t   op_kind;
    mdu_op_t    mdu_op;
    word_t      operand_a;
    word_t      operand_b;
    logic       io_write;
    logic       stall;
    word_t      result;
    logic       result_valid;
    logic       mu_start;
    word_t      mu_addr;
    word_t      mu_data;
    logic       mu_we;
    word_t      mu_q;
    logic       mu_done;
    logic       l1_clear_cache;
    logic       l1_clear_cache_done;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr_state = 32'h422b7f96;
    word_t       io_mem [16];

    multicycle_exec_stage uut (
        .clk                 (clk),
        .reset               (reset),
        .op_kind             (op_kind),
        .mdu_op              (mdu_op),
        .operand_a           (operand_a),
        .operand_b           (operand_b),
        .io_write            (io_write),
        .stall               (stall),
        .result              (result),
        .result_valid        (result_valid),
        .mu_start            (mu_start),
        .mu_addr             (mu_addr),
        .mu_data             (mu_data),
        .mu_we               (mu_we),
        .mu_q                (mu_q),
        .mu_done             (mu_done),
        .l1_clear_cache      (l1_clear_cache),
        .l1_clear_cache_done (l1_clear_cache_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==========================================================
    // Helpers
    // ==========================================================

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1 with one step per bit taken
    function automatic word_t random_bits(input int count);
        word_t value;
        logic  out_bit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // Reference results; a zero divisor gives all ones and the dividend
    function automatic word_t expected_mdu(input mdu_op_t op, input word_t a, input word_t b);
        case (op)
            MDU_DIVU: return (b == '0) ? '1 : a / b;
            MDU_MODU: return (b == '0) ? a : a % b;
            default:  return a * b;
        endcase
    endfunction

    task automatic compare_word(input string test_name, input word_t expected,
                                input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic report_counts();
        $display("Checks: %0d, errors: %0d", checks, errors);
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timed out after %0d cycles waiting for %s", RESULT_TIMEOUT, what);
        report_counts();
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // ==========================================================
    // Responder models
    // ==========================================================

    initial begin : memory_unit_model
        int    delay;
        word_t reply;
        for (int i = 0; i < 16; i++) begin
            io_mem[i] = 32'hA5A5_0000 ^ (word_t'(i) * 32'h0103_0507);
        end
        mu_q    = '0;
        mu_done = 1'b0;
        forever begin
            @(negedge clk);
            if (mu_start) begin
                delay = random_bits(3) + 1;
                reply = '0;
                // Writes answer with zero
                if (mu_we) begin
                    io_mem[mu_addr[3:0]] = mu_data;
                end else begin
                    reply = io_mem[mu_addr[3:0]];
                end
                repeat (delay) @(posedge clk);
                #DRIVE_DELAY;
                mu_q    = reply;
                mu_done = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                mu_q    = '0;
                mu_done = 1'b0;
            end
        end
    end

    initial begin : clear_cache_model
        int delay;
        l1_clear_cache_done = 1'b0;
        forever begin
            @(negedge clk);
            if (l1_clear_cache) begin
                delay = random_bits(3) + 1;
                repeat (delay) @(posedge clk);
                #DRIVE_DELAY;
                l1_clear_cache_done = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                l1_clear_cache_done = 1'b0;
            end
        end
    end

    // ==========================================================
    // Stimulus tasks
    // ==========================================================

    // Starts and ends a drive delay after a rising edge
    task automatic run_op(input string test_name, input op_kind_t kind, input mdu_op_t op,
                          input word_t a, input word_t b, input logic write,
                          input word_t expected);
        int   cycles;
        int   mdu_starts;
        int   mu_starts;
        int   clear_starts;
        int   done_pulses;
        logic got_result;
        cycles       = 0;
        mdu_starts   = 0;
        mu_starts    = 0;
        clear_starts = 0;
        done_pulses  = 0;
        got_result   = 1'b0;
        op_kind   = kind;
        mdu_op    = op;
        operand_a = a;
        operand_b = b;
        io_write  = write;
        while (!got_result) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESULT_TIMEOUT) begin
                stop_on_timeout({test_name, " result_valid"});
            end else begin
                if (cycles == 1) begin
                    compare_word({test_name, " early result_valid"}, '0,
                                 word_t'(result_valid));
                end
                if (uut.mdu_start) mdu_starts++;
                if (l1_clear_cache) clear_starts++;
                if (mu_start) begin
                    mu_starts++;
                    compare_word({test_name, " mu_addr"}, a, mu_addr);
                    compare_word({test_name, " mu_data"}, b, mu_data);
                    compare_word({test_name, " mu_we"}, word_t'(write), word_t'(mu_we));
                end else begin
                    compare_word({test_name, " idle mu_we"}, '0, word_t'(mu_we));
                end
                if ((kind == OP_MDU && uut.mdu_done) || (kind == OP_IO && mu_done) ||
                    (kind == OP_CLEAR_CACHE && l1_clear_cache_done)) begin
                    done_pulses++;
                end
                if (result_valid) begin
                    got_result = 1'b1;
                    compare_word({test_name, " stall at result"}, '0, word_t'(stall));
                    compare_word({test_name, " result"}, expected, result);
                end else begin
                    compare_word({test_name, " stall"}, 32'd1, word_t'(stall));
                end
            end
        end
        compare_word({test_name, " mdu starts"}, word_t'(kind == OP_MDU), word_t'(mdu_starts));
        compare_word({test_name, " mu starts"}, word_t'(kind == OP_IO), word_t'(mu_starts));
        compare_word({test_name, " clear starts"}, word_t'(kind == OP_CLEAR_CACHE),
                     word_t'(clear_starts));
        compare_word({test_name, " done before result"}, 32'd1, word_t'(done_pulses));
        @(posedge clk);
        #DRIVE_DELAY;
        op_kind  = OP_NONE;
        io_write = 1'b0;
    endtask

    task automatic idle_cycles(input string test_name, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            compare_word({test_name, " stall"}, '0, word_t'(stall));
            compare_word({test_name, " result_valid"}, '0, word_t'(result_valid));
            compare_word({test_name, " mu_start"}, '0, word_t'(mu_start));
            compare_word({test_name, " mu_we"}, '0, word_t'(mu_we));
            compare_word({test_name, " l1_clear_cache"}, '0, word_t'(l1_clear_cache));
            compare_word({test_name, " mdu_start"}, '0, word_t'(uut.mdu_start));
            compare_word({test_name, " mdu_done"}, '0, word_t'(uut.mdu_done));
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic multiply_cases();
        word_t a;
        word_t b;
        for (int i = 0; i < 4; i++) begin
            a = random_bits(32);
            b = random_bits(32);
            run_op("mul", OP_MDU, MDU_MUL, a, b, 1'b0, expected_mdu(MDU_MUL, a, b));
        end
        run_op("mul max", OP_MDU, MDU_MUL, '1, '1, 1'b0, expected_mdu(MDU_MUL, '1, '1));
        idle_cycles("after mul", 2);
    endtask

    task automatic divide_cases();
        word_t a;
        word_t b;
        for (int i = 0; i < 4; i++) begin
            a = random_bits(32);
            b = random_bits(32) >> random_bits(5);
            run_op("divu", OP_MDU, MDU_DIVU, a, b, 1'b0, expected_mdu(MDU_DIVU, a, b));
            run_op("modu", OP_MDU, MDU_MODU, a, b, 1'b0, expected_mdu(MDU_MODU, a, b));
        end
        a = random_bits(32);
        run_op("divu by zero", OP_MDU, MDU_DIVU, a, '0, 1'b0, '1);
        run_op("modu by zero", OP_MDU, MDU_MODU, a, '0, 1'b0, a);
        idle_cycles("after div", 2);
    endtask

    task automatic io_write_then_read();
        word_t addr;
        word_t data;
        for (int i = 0; i < 4; i++) begin
            addr = random_bits(32);
            data = random_bits(32);
            run_op("io write", OP_IO, MDU_MUL, addr, data, 1'b1, '0);
            run_op("io read", OP_IO, MDU_MUL, addr, random_bits(32), 1'b0, data);
        end
        idle_cycles("after io", 2);
    endtask

    task automatic clear_cache_cases();
        run_op("clear cache", OP_CLEAR_CACHE, MDU_MUL, random_bits(32), random_bits(32),
               1'b0, '0);
        run_op("clear cache again", OP_CLEAR_CACHE, MDU_MUL, '0, '0, 1'b0, '0);
        idle_cycles("after clear", 2);
    endtask

    // Each operation is presented in the cycle after the previous result
    task automatic mixed_back_to_back();
        word_t a;
        word_t b;
        word_t data;
        a    = random_bits(32);
        b    = random_bits(32);
        data = random_bits(32);
        run_op("b2b mul", OP_MDU, MDU_MUL, a, b, 1'b0, expected_mdu(MDU_MUL, a, b));
        run_op("b2b write", OP_IO, MDU_MUL, 32'h0000_0007, data, 1'b1, '0);
        run_op("b2b read", OP_IO, MDU_MUL, 32'h0000_0007, a, 1'b0, data);
        run_op("b2b clear", OP_CLEAR_CACHE, MDU_MUL, a, b, 1'b0, '0);
        run_op("b2b divu", OP_MDU, MDU_DIVU, a, b >> 8, 1'b0, expected_mdu(MDU_DIVU, a, b >> 8));
        run_op("b2b read 2", OP_IO, MDU_MUL, 32'h0000_0007, b, 1'b0, data);
        run_op("b2b modu", OP_MDU, MDU_MODU, a, b >> 8, 1'b0, expected_mdu(MDU_MODU, a, b >> 8));
        idle_cycles("after b2b", 4);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        reset     = 1'b1;
        op_kind   = OP_NONE;
        mdu_op    = MDU_MUL;
        operand_a = '0;
        operand_b = '0;
        io_write  = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        idle_cycles("reset", 3);
        multiply_cases();
        divide_cases();
        io_write_then_read();
        clear_cache_cases();
        mixed_back_to_back();

        report_counts();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
verilog/exec_data_pkg.sv
verilog/exec_ctrl_pkg.sv
verilog/mdu_iteration_counter.sv
verilog/mdu_datapath.sv
verilog/long_op_sequencer.sv
verilog/multicycle_exec_stage.sv
verification/tb_multicycle_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator; exit status follows the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_multicycle_exec_stage -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
